/* include/rv_core_params.svh */
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Datapath and instruction word width
`define RV_XLEN 32

// Architectural integer registers x0..x31
`define RV_NREGS 32

// Data memory depth in 32-bit words, addresses wrap at this size
`define RV_DMEM_WORDS 256

`endif

/* src/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011, // Register-register ALU
		OPC_OP_IMM = 7'b0010011, // Register-immediate ALU
		OPC_LUI    = 7'b0110111, // Load upper immediate
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_PASS_B // Operand B straight through, for LUI
	} alu_op_e;

	typedef enum logic [1:0] {
		IMM_I, IMM_I_SHAMT, IMM_S, IMM_U
	} imm_sel_e;

	// Encoded as the load/store funct3
	typedef enum logic [2:0] {
		MEM_BYTE   = 3'b000,
		MEM_HALF   = 3'b001,
		MEM_WORD   = 3'b010,
		MEM_BYTE_U = 3'b100,
		MEM_HALF_U = 3'b101
	} mem_size_e;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM
	} wb_sel_e;

	typedef struct packed {
		alu_op_e   alu_op;
		logic      sel_op_b; // 1 picks the immediate
		logic      is_store;
		logic      is_load;
		logic      wr_en;    // Register file write
		mem_size_e mem_size;
		wb_sel_e   wb_sel;
	} ctrl_t;

endpackage

`default_nettype wire

/* src/stage_ifs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_params.svh"

// Decode to execute
interface id_ex_if import rv_core_pkg::*; ();
	logic               valid;
	ctrl_t              ctrl;
	logic [`RV_XLEN-1:0] op_a;  // rs1 read data
	logic [`RV_XLEN-1:0] op_b;  // rs2 read data
	logic [`RV_XLEN-1:0] imm;
	logic [4:0]          rd;

	modport dec (
		output valid, ctrl, op_a, op_b, imm, rd
	);
	modport ex (
		input valid, ctrl, op_a, op_b, imm, rd
	);
endinterface

// Execute to result
interface ex_wb_if import rv_core_pkg::*; ();
	logic               valid;
	ctrl_t              ctrl;
	logic [`RV_XLEN-1:0] alu_res;    // Address for loads and stores
	logic [`RV_XLEN-1:0] store_data;
	logic [4:0]          rd;

	modport src (
		output valid, ctrl, alu_res, store_data, rd
	);
	modport snk (
		input valid, ctrl, alu_res, store_data, rd
	);
endinterface

`default_nettype wire

/* src/id_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module id_ctrl import rv_core_pkg::*; (
	input  logic [6:0] opcode,
	input  logic [2:0] funct3,
	input  logic [6:0] funct7,
	output ctrl_t      ctrl,
	output imm_sel_e   imm_sel,
	output logic       legal
);

	// Shared funct3 map for OP and OP-IMM, alt picks SUB or SRA
	function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	logic f7_zero; // funct7 all clear
	logic f7_alt;  // funct7 = 0100000

	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);

	always_comb begin
		ctrl.alu_op   = ALU_ADD;  // Safe defaults, nothing written
		ctrl.sel_op_b = 1'b0;
		ctrl.is_store = 1'b0;
		ctrl.is_load  = 1'b0;
		ctrl.wr_en    = 1'b0;
		ctrl.mem_size = MEM_WORD;
		ctrl.wb_sel   = WB_ALU;
		imm_sel       = IMM_I;
		legal         = 1'b1;
		case (opcode)
			OPC_OP: begin
				ctrl.wr_en  = 1'b1;
				ctrl.alu_op = alu_from_f3(funct3, funct7[5]);
				// Alt encoding only exists for SUB and SRA
				legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			OPC_OP_IMM: begin
				ctrl.wr_en    = 1'b1;
				ctrl.sel_op_b = 1'b1;
				ctrl.alu_op   = alu_from_f3(funct3, (funct3 == 3'b101) && funct7[5]);
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					imm_sel = IMM_I_SHAMT;             // Shifts take a 5-bit amount
					legal   = f7_zero || (funct3 == 3'b101 && f7_alt);
				end
			end
			OPC_LUI: begin
				ctrl.wr_en    = 1'b1;
				ctrl.sel_op_b = 1'b1;
				ctrl.alu_op   = ALU_PASS_B;            // rs1 field is ignored
				imm_sel       = IMM_U;
			end
			OPC_LOAD: begin
				ctrl.wr_en    = 1'b1;
				ctrl.is_load  = 1'b1;
				ctrl.sel_op_b = 1'b1;                  // Base plus offset
				ctrl.wb_sel   = WB_MEM;
				ctrl.mem_size = mem_size_e'(funct3);
				legal         = (funct3 != 3'b011) && (funct3 <= 3'b101);
			end
			OPC_STORE: begin
				ctrl.is_store = 1'b1;
				ctrl.sel_op_b = 1'b1;
				ctrl.mem_size = mem_size_e'(funct3);
				imm_sel       = IMM_S;
				legal         = (funct3 <= 3'b010);    // sb, sh, sw only
			end
			default: legal = 1'b0;                   // Unsupported major opcode
		endcase
	end

endmodule

`default_nettype wire

/* src/id_imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_params.svh"

module id_imm_gen import rv_core_pkg::*; (
	input  imm_sel_e            imm_sel,
	input  logic [24:0]         inst_hi,  // Instruction bits 31..7
	output logic [`RV_XLEN-1:0] imm
);

	logic sign; // Instruction bit 31

	assign sign = inst_hi[24];

	always_comb begin
		case (imm_sel)
			// inst[31:20]
			IMM_I:       imm = {{20{sign}}, inst_hi[24:13]};
			// inst[24:20], zero extended
			IMM_I_SHAMT: imm = {27'd0, inst_hi[17:13]};
			// inst[31:25] and inst[11:7]
			IMM_S:       imm = {{20{sign}}, inst_hi[24:18], inst_hi[4:0]};
			// inst[31:12] in the upper bits
			default:     imm = {inst_hi[24:5], 12'd0};
		endcase
	end

endmodule

`default_nettype wire

/* src/id_dec.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_params.svh"

module id_dec import rv_core_pkg::*; (
	input  logic                inst_valid,
	input  logic [`RV_XLEN-1:0] inst,
	output logic [4:0]          rs1_addr,
	output logic [4:0]          rs2_addr,
	input  logic [`RV_XLEN-1:0] rs1_data,
	input  logic [`RV_XLEN-1:0] rs2_data,
	id_ex_if.dec                id_ex
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	ctrl_t      ctrl;
	imm_sel_e   imm_sel;  // Only used inside decode
	logic       legal;

	// Standard RV32 field positions
	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	id_ctrl u_ctrl (
		.opcode (opcode),
		.funct3 (funct3),
		.funct7 (funct7),
		.ctrl   (ctrl),
		.imm_sel(imm_sel),
		.legal  (legal)
	);

	id_imm_gen u_imm_gen (
		.imm_sel(imm_sel),
		.inst_hi(inst[31:7]),
		.imm    (id_ex.imm)
	);

	assign id_ex.valid = inst_valid && legal; // Illegal word becomes a bubble
	assign id_ex.ctrl  = ctrl;
	assign id_ex.op_a  = rs1_data;
	assign id_ex.op_b  = rs2_data;
	assign id_ex.rd    = inst[11:7];

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_params.svh"

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [4:0]          rs1_addr,
	input  logic [4:0]          rs2_addr,
	output logic [`RV_XLEN-1:0] rs1_data,
	output logic [`RV_XLEN-1:0] rs2_data,
	input  logic                we,
	input  logic [4:0]          wr_addr,
	input  logic [`RV_XLEN-1:0] wr_data
);

	logic [`RV_XLEN-1:0] regs [`RV_NREGS]; // Entry 0 is never read

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr]; // x0 hardwired
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* src/ex_alu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_params.svh"

module ex_alu import rv_core_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	id_ex_if.ex  id_ex,
	ex_wb_if.src ex_wb
);

	logic                ex_valid;
	ctrl_t               ex_ctrl;
	logic [`RV_XLEN-1:0] ex_op_a;
	logic [`RV_XLEN-1:0] ex_op_b;  // rs2 value, also store data
	logic [`RV_XLEN-1:0] ex_imm;
	logic [4:0]          ex_rd;
	logic [`RV_XLEN-1:0] opb_mux;
	logic [4:0]          shamt;
	logic [`RV_XLEN-1:0] alu_out;

	// ID/EX register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= id_ex.valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_ctrl <= id_ex.ctrl; // Payload, only meaningful with ex_valid
		ex_op_a <= id_ex.op_a;
		ex_op_b <= id_ex.op_b;
		ex_imm  <= id_ex.imm;
		ex_rd   <= id_ex.rd;
	end

	assign opb_mux = ex_ctrl.sel_op_b ? ex_imm : ex_op_b;
	assign shamt   = opb_mux[4:0]; // Low 5 bits only

	always_comb begin
		case (ex_ctrl.alu_op)
			ALU_ADD:    alu_out = ex_op_a + opb_mux;
			ALU_SUB:    alu_out = ex_op_a - opb_mux;
			ALU_SLL:    alu_out = ex_op_a << shamt;
			ALU_SLT:    alu_out = {31'd0, $signed(ex_op_a) < $signed(opb_mux)};
			ALU_SLTU:   alu_out = {31'd0, ex_op_a < opb_mux};
			ALU_XOR:    alu_out = ex_op_a ^ opb_mux;
			ALU_SRL:    alu_out = ex_op_a >> shamt;
			ALU_SRA:    alu_out = $unsigned($signed(ex_op_a) >>> shamt);
			ALU_OR:     alu_out = ex_op_a | opb_mux;
			ALU_AND:    alu_out = ex_op_a & opb_mux;
			ALU_PASS_B: alu_out = opb_mux;  // LUI
			default:    alu_out = '0;
		endcase
	end

	// EX/WB register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_wb.valid <= 1'b0;
		end else begin
			ex_wb.valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_wb.ctrl       <= ex_ctrl;
		ex_wb.alu_res    <= alu_out;
		ex_wb.store_data <= ex_op_b;
		ex_wb.rd         <= ex_rd;
	end

endmodule

`default_nettype wire

/* src/wb_result.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_params.svh"

module wb_result import rv_core_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	ex_wb_if.snk                ex_wb,
	output logic                rf_we,
	output logic [4:0]          rf_addr,
	output logic [`RV_XLEN-1:0] rf_data,
	output logic                retire_valid,
	output logic [4:0]          retire_rd,
	output logic [`RV_XLEN-1:0] retire_data
);

	localparam int WIDX = $clog2(`RV_DMEM_WORDS); // Word index bits

	logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
	logic [WIDX-1:0]     widx;
	logic [1:0]          boff;     // Byte offset in word
	logic [3:0]          be;
	logic [`RV_XLEN-1:0] wdata;    // Store data replicated over lanes
	logic [`RV_XLEN-1:0] rd_word;
	logic [7:0]          ld_byte;
	logic [15:0]         ld_half;
	logic [`RV_XLEN-1:0] ld_val;

	assign widx = ex_wb.alu_res[WIDX+1:2]; // Wraps modulo depth
	assign boff = ex_wb.alu_res[1:0];

	always_comb begin
		case (ex_wb.ctrl.mem_size)
			MEM_BYTE, MEM_BYTE_U: begin
				be    = 4'b0001 << boff;
				wdata = {4{ex_wb.store_data[7:0]}};
			end
			MEM_HALF, MEM_HALF_U: begin
				be    = boff[1] ? 4'b1100 : 4'b0011; // Bit 0 ignored
				wdata = {2{ex_wb.store_data[15:0]}};
			end
			default: begin
				be    = 4'b1111;
				wdata = ex_wb.store_data;
			end
		endcase
	end

	// Lane-merged store at the third edge
	always_ff @(posedge clk) begin
		if (ex_wb.valid && ex_wb.ctrl.is_store) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i]) dmem[widx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	assign rd_word = dmem[widx];
	assign ld_byte = rd_word[8*boff +: 8];
	assign ld_half = boff[1] ? rd_word[31:16] : rd_word[15:0];

	always_comb begin
		case (ex_wb.ctrl.mem_size)
			MEM_BYTE:   ld_val = {{24{ld_byte[7]}}, ld_byte};
			MEM_BYTE_U: ld_val = {24'd0, ld_byte};
			MEM_HALF:   ld_val = {{16{ld_half[15]}}, ld_half};
			MEM_HALF_U: ld_val = {16'd0, ld_half};
			default:    ld_val = rd_word;
		endcase
	end

	// Register write in the valid cycle, x0 never sent
	assign rf_we   = ex_wb.valid && ex_wb.ctrl.wr_en && (ex_wb.rd != 5'd0);
	assign rf_addr = ex_wb.rd;
	assign rf_data = (ex_wb.ctrl.wb_sel == WB_MEM) ? ld_val : ex_wb.alu_res;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= rf_we; // One-cycle pulse per retired write
		end
	end

	always_ff @(posedge clk) begin
		if (rf_we) begin
			retire_rd   <= rf_addr;
			retire_data <= rf_data;
		end
	end

endmodule

`default_nettype wire

/* src/rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_params.svh"

module rv_core_top import rv_core_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                inst_valid,
	input  logic [`RV_XLEN-1:0] inst,
	output logic                retire_valid,
	output logic [4:0]          retire_rd,
	output logic [`RV_XLEN-1:0] retire_data
);

	logic [4:0]          rs1_addr;
	logic [4:0]          rs2_addr;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic                rf_we;    // From result stage
	logic [4:0]          rf_addr;
	logic [`RV_XLEN-1:0] rf_data;

	id_ex_if u_id_ex ();
	ex_wb_if u_ex_wb ();

	id_dec u_dec (
		.inst_valid(inst_valid),
		.inst      (inst),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.id_ex     (u_id_ex.dec)
	);

	reg_file u_rf (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.we      (rf_we),
		.wr_addr (rf_addr),
		.wr_data (rf_data)
	);

	ex_alu u_ex (
		.clk  (clk),
		.rst_n(rst_n),
		.id_ex(u_id_ex.ex),
		.ex_wb(u_ex_wb.src)
	);

	wb_result u_wb (
		.clk         (clk),
		.rst_n       (rst_n),
		.ex_wb       (u_ex_wb.snk),
		.rf_we       (rf_we),
		.rf_addr     (rf_addr),
		.rf_data     (rf_data),
		.retire_valid(retire_valid),
		.retire_rd   (retire_rd),
		.retire_data (retire_data)
	);

endmodule

`default_nettype wire

/* bench/tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_params.svh"

module tb_rv_core;

	localparam int N_RAND  = 300;                  // Random instructions
	localparam int N_INST  = 2 + 62 + 16 + 2 + N_RAND + 31 + 16;
	localparam int TIMEOUT = N_INST * 3 + 50;      // Cycles

	logic                clk;
	logic                rst_n;
	logic                inst_valid;
	logic [`RV_XLEN-1:0] inst;
	logic                retire_valid;
	logic [4:0]          retire_rd;
	logic [`RV_XLEN-1:0] retire_data;

	logic [31:0] lfsr_state;
	logic [31:0] regs_m [32];                      // Model register file
	logic [31:0] mem_m [`RV_DMEM_WORDS];           // Model data memory
	logic [4:0]  exp_rd[$];                        // Expected retires in order
	logic [31:0] exp_data[$];
	int          exp_cyc[$];                       // Cycle of the retire sample
	int          rd_ptr;                           // Next expected entry
	int          errors;
	int          cycle;

	rv_core_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.retire_valid(retire_valid),
		.retire_rd   (retire_rd),
		.retire_data (retire_data)
	);

	always #5 clk = ~clk;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};          // One step per bit
		end
		return v;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'h37};
	endfunction

	// Offset so that base plus offset hits target modulo 1 KiB
	function automatic logic [11:0] offset_to(input logic [4:0] base, input logic [9:0] target);
		logic [9:0] d;
		d = target - regs_m[base][9:0];
		return {{2{d[9]}}, d};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'd0, $signed(a) < $signed(b)};
			3'd3:    return {31'd0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] load_ext(input logic [31:0] w, input logic [1:0] off,
		input logic [2:0] f3);
		logic [7:0]  bt;
		logic [15:0] hf;
		bt = 8'(w >> (8 * off));
		hf = 16'(w >> (off[1] ? 16 : 0));          // Aligned half lane
		case (f3)
			3'd0:    return {{24{bt[7]}}, bt};
			3'd4:    return {24'd0, bt};
			3'd1:    return {{16{hf[15]}}, hf};
			3'd5:    return {16'd0, hf};
			default: return w;
		endcase
	endfunction

	function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [31:0] data,
		input logic [1:0] off, input logic [2:0] f3);
		logic [31:0] mask;
		logic [31:0] lanes;
		case (f3)
			3'd0: begin
				mask  = 32'hff << (8 * off);
				lanes = (data & 32'hff) << (8 * off);
			end
			3'd1: begin
				mask  = off[1] ? 32'hffff_0000 : 32'h0000_ffff;
				lanes = off[1] ? {data[15:0], 16'h0} : {16'h0, data[15:0]};
			end
			default: begin
				mask  = '1;
				lanes = data;
			end
		endcase
		return (old & ~mask) | lanes;
	endfunction

	// Executes one word on the model state and queues its retire
	function automatic void run_model(input logic [31:0] ins, input int cyc);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] i_imm;
		logic [31:0] s_imm;
		logic [31:0] res;
		logic [31:0] addr;
		logic        legal;
		logic        writes;
		rd     = ins[11:7];
		f3     = ins[14:12];
		f7     = ins[31:25];
		a      = regs_m[ins[19:15]];
		b      = regs_m[ins[24:20]];
		i_imm  = {{20{ins[31]}}, ins[31:20]};
		s_imm  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		legal  = 1'b1;
		writes = 1'b1;
		res    = '0;
		case (ins[6:0])
			7'h33: begin                                 // OP
				legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				res   = alu_ref(f3, f7[5], a, b);
			end
			7'h13: begin                                 // OP-IMM
				if (f3 == 3'd1) legal = (f7 == 7'h00);
				else if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
				res = alu_ref(f3, f3 == 3'd5 && f7[5], a, i_imm);
			end
			7'h37: res = {ins[31:12], 12'h000};          // LUI
			7'h03: begin
				legal = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
				addr  = a + i_imm;
				res   = load_ext(mem_m[addr[9:2]], addr[1:0], f3);
			end
			7'h23: begin
				legal  = (f3 <= 3'd2);
				writes = 1'b0;
				addr   = a + s_imm;
				if (legal) mem_m[addr[9:2]] = store_merge(mem_m[addr[9:2]], b, addr[1:0], f3);
			end
			default: legal = 1'b0;
		endcase
		if (legal && writes && rd != 5'd0) begin
			regs_m[rd] = res;
			exp_rd.push_back(rd);
			exp_data.push_back(res);
			exp_cyc.push_back(cyc + 3);                  // Three cycles after the strobe
		end
	endfunction

	// One strobe, then two idle cycles
	task automatic issue(input logic [31:0] ins);
		@(negedge clk);
		inst_valid = 1'b1;
		inst       = ins;
		run_model(ins, cycle);
		@(negedge clk);
		inst_valid = 1'b0;
		inst       = '0;
		@(negedge clk);
	endtask

	task automatic issue_random();
		logic [2:0]  kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [9:0]  target;
		logic [31:0] ins;
		kind   = 3'(rand_bits(3));
		rd     = 5'(rand_bits(5));
		rs1    = 5'(rand_bits(5));
		rs2    = 5'(rand_bits(5));
		f3     = 3'(rand_bits(3));
		f7     = rand_bits(1) ? 7'h20 : 7'h00;
		target = 10'(rand_bits(6));                    // Bytes 0..63, all stored
		case (kind)
			3'd0, 3'd1: ins = enc_r(f7, rs2, rs1, f3, rd, 7'h33);
			3'd2, 3'd3: begin
				if (f3 == 3'd1 || f3 == 3'd5) ins = enc_i({f7, rs2}, rs1, f3, rd, 7'h13);
				else ins = enc_i(12'(rand_bits(12)), rs1, f3, rd, 7'h13);
			end
			3'd4: ins = enc_u(20'(rand_bits(20)), rd);
			3'd5: ins = enc_i(offset_to(rs1, target), rs1, f3, rd, 7'h03);
			3'd6: ins = enc_s(offset_to(rs1, target), rs2, rs1, {1'b0, f3[1:0]});
			default: begin
				ins = rand_bits(32);
				// Unsupported major opcode
				if (ins[6:0] inside {7'h33, 7'h13, 7'h37, 7'h03, 7'h23}) ins[6] = 1'b1;
			end
		endcase
		issue(ins);
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT) begin
			$display("Timeout after %0d cycles with %0d retires still outstanding",
				cycle, exp_rd.size() - rd_ptr);
			$display("Testbench failed");
			$finish;
		end
	end

	// Comparator, outputs sampled before they update
	always @(posedge clk) begin
		if (retire_valid === 1'b1) begin
			if (rd_ptr >= exp_rd.size()) begin
				$display("%0t ns: retire of x%0d when no instruction was due", $time, retire_rd);
				errors = errors + 1;
			end else begin
				if (retire_rd !== exp_rd[rd_ptr]) begin
					$display("error %0t ns: retire_rd is %0d, expected %0d",
						$time, retire_rd, exp_rd[rd_ptr]);
					errors = errors + 1;
				end
				if (retire_data !== exp_data[rd_ptr]) begin
					$display("error %0t ns: retire_data is %h, expected %h",
						$time, retire_data, exp_data[rd_ptr]);
					errors = errors + 1;
				end
				if (cycle != exp_cyc[rd_ptr]) begin
					$display("error %0t ns: retire cycle is %0d, expected %0d",
						$time, cycle, exp_cyc[rd_ptr]);
					errors = errors + 1;
				end
				rd_ptr = rd_ptr + 1;
			end
		end
	end

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		cycle      = 0;
		rd_ptr     = 0;
		errors     = 0;
		lfsr_state = 32'h7ffc8a41;
		for (int r = 0; r < 32; r++) begin
			regs_m[r] = '0;
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		issue(32'hffff_ffff);                          // Illegal, no retire
		issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'h33));
		for (int r = 1; r < 32; r++) begin             // LUI then ADDI per register
			issue(enc_u(20'(rand_bits(20)), 5'(r)));
			issue(enc_i(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r), 7'h13));
		end
		for (int i = 0; i < 16; i++) begin             // Fill words 0..15
			issue(enc_s(12'(4 * i), 5'(rand_bits(5)), 5'd0, 3'd2));
		end
		issue(enc_i(12'h055, 5'd1, 3'd0, 5'd0, 7'h13)); // Write to x0
		issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd2, 7'h33));
		repeat (N_RAND) issue_random();
		for (int r = 1; r < 32; r++) begin             // Read back every register
			issue(enc_r(7'h00, 5'd0, 5'(r), 3'd0, 5'(r), 7'h33));
		end
		for (int i = 0; i < 16; i++) begin             // Read back every word
			issue(enc_i(12'(4 * i), 5'd0, 3'd2, 5'd1, 7'h03));
		end
		while (rd_ptr < exp_rd.size()) @(negedge clk);
		repeat (4) @(negedge clk);                     // Catch late spurious retires
		$display("Checked %0d of %0d expected retires, %0d errors",
			rd_ptr, exp_rd.size(), errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
src/rv_core_pkg.sv
src/stage_ifs.sv
src/id_ctrl.sv
src/id_imm_gen.sv
src/id_dec.sv
src/reg_file.sv
src/ex_alu.sv
src/wb_result.sv
src/rv_core_top.sv
bench/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
